/* Makefile */
# Verilator build and run for the tile line renderer testbench

VERILATOR ?= verilator
TOP ?= vid_tb
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= STATUS: FAIL
PASS_MSG ?= STATUS: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/vid_scan_chk.sv */
/*
 concurrent checks on the scan control credit counter and pixel issue
 bound into every vid_scan_ctrl instance
*/
`timescale 1ns/100ps

module vid_scan_chk (
	input logic clk,
	input logic reset,
	input vid_pkg::credit_t credits,
	input logic issue,
	input logic pix_credit,
	input logic end_of_frame,
	input logic busy
);

	int outstanding;  // issued and not yet credited back

	always_ff @(posedge clk) begin
		if (reset)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(issue) - int'(pix_credit);
	end

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= vid_pkg::credit_t'(vid_pkg::credits_init))
		else $error("credit count above its initial value");

	a_no_issue_empty: assert property (@(posedge clk) disable iff (reset)
		issue |-> outstanding < vid_pkg::credits_init)
		else $error("pixel issued with no credit");

	// last pixel of the final line must precede the drop of busy
	a_busy_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> $past(issue && end_of_frame))
		else $error("busy fell before the final pixel");

endmodule

bind vid_scan_ctrl vid_scan_chk chk0 (
	.clk(clk), .reset(reset), .credits(credits), .issue(issue),
	.pix_credit(pix_credit), .end_of_frame(end_of_frame), .busy(busy)
);

/* bench/vid_tb.sv */
/*
 directed testbench for the tile line renderer
 loads registers and memories over the cpu port, renders frames under
 several credit policies and compares every pixel with a reference model
*/
`timescale 1ns/100ps

module vid_tb;

	localparam int npix = vid_pkg::screen_w * vid_pkg::screen_h;
	localparam int max_gap = 50;
	localparam int frames = 5;
	localparam int mem_ops = 3 + 32 + 2 * 256 + 2048 + 8;
	localparam int frame_bound = npix * (max_gap + vid_pkg::pix_latency + 2) + 200;
	localparam longint limit_cycles = 8 * mem_ops + frames * frame_bound;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [15:0] addr = '0;
	logic [31:0] din = '0;
	logic [3:0] wstrb = '0;
	logic ren = 1'b0;
	logic frame_start = 1'b0;
	logic pix_credit = 1'b0;
	logic [31:0] dout;
	logic ready, busy, pix_valid, pix_first, pix_last;
	logic [23:0] pix_data;

	integer seed = 48;
	int errors = 0;
	int checks = 0;

	// reference state
	logic [23:0] pal [32];
	logic [7:0] map_a [256];
	logic [7:0] map_b [256];
	logic [31:0] tiles [2048];
	int m_layer_en = 0;
	int sax = 0, say = 0, sbx = 0, sby = 0;

	vid_line_renderer dut0 (
		.clk(clk), .reset(reset),
		.addr(addr), .din(din), .wstrb(wstrb), .ren(ren),
		.dout(dout), .ready(ready),
		.frame_start(frame_start), .busy(busy),
		.pix_valid(pix_valid), .pix_data(pix_data),
		.pix_first(pix_first), .pix_last(pix_last), .pix_credit(pix_credit)
	);

	always #50 clk = ~clk;

	function automatic int rand_below(int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	task automatic expect_value(string what, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// one layer's colour index at screen position x,y
	function automatic int layer_index(int x, int y, bit use_b);
		int sx, sy, entry, tno;
		logic [31:0] row;
		sx = (x + (use_b ? sbx : sax)) % 256;
		sy = (y + (use_b ? sby : say)) % 256;
		entry = ((sy / 8) % 16) * 16 + (sx / 8) % 16;
		tno = use_b ? map_b[entry] : map_a[entry];
		row = tiles[tno * 8 + sy % 8];
		return (row >> ((sx % 8) * 4)) & 15;
	endfunction

	function automatic logic [23:0] model_pixel(int x, int y);
		int ia, ib;
		ia = layer_index(x, y, 1'b0);
		ib = layer_index(x, y, 1'b1);
		if (m_layer_en[0] && ia != 0)
			return pal[16 + ia];
		else if (m_layer_en[1] && ib != 0)
			return pal[ib];
		return pal[0];
	endfunction

	task automatic wait_ready();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!ready && n < 10);
		if (!ready) begin
			errors++;
			$display("ready never rose for cpu access at %h, time %0t", addr, $time);
		end
	endtask

	task automatic cpu_write(logic [15:0] a, logic [31:0] d);
		addr <= a;
		din <= d;
		wstrb <= 4'hf;
		wait_ready();
		wstrb <= 4'h0;
		@(posedge clk);  // let ready drop between requests
	endtask

	task automatic cpu_read(logic [15:0] a, output logic [31:0] d);
		addr <= a;
		ren <= 1'b1;
		wait_ready();
		d = dout;
		ren <= 1'b0;
		@(posedge clk);
	endtask

	task automatic set_layers(int en, logic [31:0] sa, logic [31:0] sb);
		cpu_write(16'h0000, en);
		cpu_write(16'h0004, sa);
		cpu_write(16'h0008, sb);
		m_layer_en = en & 3;
		sax = sa[7:0];
		say = sa[23:16];
		sbx = sb[7:0];
		sby = sb[23:16];
	endtask

	// policy 0 returns credits at once, policy 1 in bursts with gaps
	task automatic run_frame(int policy, bit restart);
		int count, owed, gap, burst, cyc;
		count = 0;
		owed = 0;
		gap = 0;
		burst = 1;
		cyc = 0;
		frame_start <= 1'b1;
		@(posedge clk);
		frame_start <= 1'b0;
		while (count < npix || owed > 0) begin
			@(posedge clk);
			cyc++;
			frame_start <= restart && (cyc == 100);  // must be ignored
			if (pix_valid) begin
				expect_value("pixel colour", pix_data, model_pixel(count % 64, count / 64));
				expect_value("first flag", pix_first, count == 0);
				expect_value("last flag", pix_last, (count % 64) == 63);
				count++;
				owed++;
			end
			if (owed > vid_pkg::credits_init) begin
				errors++;
				$display("FAILED %0t: %0d pixels outstanding", $time, owed);
			end
			if (policy == 0 || gap == 0) begin
				pix_credit <= (owed > 0);
				if (owed > 0) begin
					owed--;
					burst--;
					if (policy != 0 && burst == 0) begin
						gap = 20 + rand_below(max_gap - 19);
						burst = 1 + rand_below(4);
					end
				end
			end else begin
				pix_credit <= 1'b0;
				gap--;
			end
		end
		@(posedge clk);  // final credit pulse is one cycle wide
		pix_credit <= 1'b0;
		frame_start <= 1'b0;
		repeat (vid_pkg::pix_latency + 2) begin
			@(posedge clk);
			if (pix_valid)
				count++;  // stray pixel past the frame
		end
		expect_value("pixel count", count, npix);
		expect_value("busy after frame", busy, 0);
	endtask

	task automatic test_registers();
		logic [31:0] d, sa, sb;
		expect_value("ready after reset", ready, 0);
		expect_value("busy after reset", busy, 0);
		expect_value("pix_valid after reset", pix_valid, 0);
		for (int i = 0; i < 3; i++) begin
			cpu_read(16'(i * 4), d);
			expect_value("register reset value", d, 0);
		end
		sa = $random(seed);
		sb = $random(seed);
		set_layers(32'hffff_fffd, sa, sb);
		cpu_read(16'h0000, d);
		expect_value("layer_en", d, 1);
		cpu_read(16'h0004, d);
		expect_value("scroll a", d, sa & 32'h00ff_00ff);
		cpu_read(16'h0008, d);
		expect_value("scroll b", d, sb & 32'h00ff_00ff);
	endtask

	task automatic test_memories();
		logic [31:0] w, d;
		for (int i = 0; i < 32; i++) begin
			w = $random(seed);
			pal[i] = w[23:0];
			cpu_write(16'h1000 + 16'(i * 4), w);
		end
		for (int i = 0; i < 256; i++) begin
			w = $random(seed);
			map_a[i] = w[7:0];
			cpu_write(16'h2000 + 16'(i * 4), w);
			w = $random(seed);
			map_b[i] = w[7:0];
			cpu_write(16'h3000 + 16'(i * 4), w);
		end
		for (int i = 0; i < 2048; i++) begin
			tiles[i] = $random(seed) & $random(seed);  // about a third of nibbles zero
			cpu_write(16'h8000 + 16'(i * 4), tiles[i]);
		end
		for (int i = 0; i < 32; i++) begin
			cpu_read(16'h1000 + 16'(i * 4), d);
			expect_value("palette readback", d, {8'h00, pal[i]});
		end
		for (int i = 0; i < 256; i++) begin
			cpu_read(16'h2000 + 16'(i * 4), d);
			expect_value("map a readback", d, {24'h0, map_a[i]});
			cpu_read(16'h3000 + 16'(i * 4), d);
			expect_value("map b readback", d, {24'h0, map_b[i]});
		end
		for (int i = 0; i < 2048; i++) begin
			cpu_read(16'h8000 + 16'(i * 4), d);
			expect_value("tile readback", d, tiles[i]);
		end
	endtask

	task automatic test_frame_control();
		run_frame(0, 1'b1);
		repeat (20) begin
			@(posedge clk);
			if (pix_valid || busy) begin
				errors++;
				$display("second frame started from a pulse during busy, time %0t", $time);
			end
		end
		run_frame(0, 1'b0);
	endtask

	initial begin
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		test_registers();
		test_memories();
		set_layers(1, 0, 0);                      // single layer
		run_frame(0, 1'b0);
		set_layers(3, 32'h0078_0070, 32'h00e8_00f0);  // both layers with wrapping scroll
		run_frame(0, 1'b0);
		run_frame(1, 1'b0);                       // back-pressure
		test_frame_control();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		#(limit_cycles * 100);
		$display("timeout after %0d cycles, test did not complete", limit_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* compile.f */
verilog/vid_pkg.sv
verilog/vid_scan_if.sv
verilog/vid_dpram.sv
verilog/vid_cpu_regs.sv
verilog/vid_scan_ctrl.sv
verilog/vid_tile_fetch.sv
verilog/vid_pixel_out.sv
verilog/vid_line_renderer.sv
bench/vid_scan_chk.sv
bench/vid_tb.sv

/* verilog/vid_cpu_regs.sv */
/*
 cpu slave port: region decode, control registers and readback mux
 ready follows a request by one cycle and holds while the request does;
 writes need all four byte strobes
*/
`timescale 1ns/100ps

module vid_cpu_regs (
	input logic clk,
	input logic reset,
	input vid_pkg::cpu_addr_t addr,
	input vid_pkg::cpu_data_t din,
	input logic [3:0] wstrb,
	input logic ren,
	output vid_pkg::cpu_data_t dout,
	output logic ready,
	output logic wr_palette,
	output logic wr_map_a,
	output logic wr_map_b,
	output logic wr_tiles,
	input vid_pkg::rgb_t rd_palette,
	input vid_pkg::tile_no_t rd_map_a,
	input vid_pkg::tile_no_t rd_map_b,
	input vid_pkg::cpu_data_t rd_tiles,
	output logic [1:0] layer_en,
	output vid_pkg::scroll_t scroll_ax,
	output vid_pkg::scroll_t scroll_ay,
	output vid_pkg::scroll_t scroll_bx,
	output vid_pkg::scroll_t scroll_by
);

	logic req;
	logic req_q;
	logic wr_ok;
	logic [3:0] region;
	logic [3:0] reg_idx;
	logic sel_regs, sel_palette, sel_map_a, sel_map_b, sel_tiles;
	logic regs_q, palette_q, map_a_q, map_b_q, tiles_q;
	logic [3:0] reg_idx_q;

	assign req = (wstrb != 4'b0000) || ren;
	assign wr_ok = &wstrb;
	assign region = addr[15:12];
	assign reg_idx = addr[5:2];

	assign sel_tiles = addr[15];
	assign sel_regs = (region == 4'(vid_pkg::region_regs));
	assign sel_palette = (region == 4'(vid_pkg::region_palette));
	assign sel_map_a = (region == 4'(vid_pkg::region_map_a));
	assign sel_map_b = (region == 4'(vid_pkg::region_map_b));

	assign wr_palette = wr_ok && sel_palette;
	assign wr_map_a = wr_ok && sel_map_a;
	assign wr_map_b = wr_ok && sel_map_b;
	assign wr_tiles = wr_ok && sel_tiles;   // both layer copies

	assign ready = req_q && req;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			layer_en <= 2'b00;
			scroll_ax <= '0;
			scroll_ay <= '0;
			scroll_bx <= '0;
			scroll_by <= '0;
		end else begin
			req_q <= req;
			if (wr_ok && sel_regs) begin
				case (reg_idx)
					4'(vid_pkg::reg_layer_en): layer_en <= din[1:0];
					4'(vid_pkg::reg_scroll_a): begin
						scroll_ax <= din[7:0];
						scroll_ay <= din[23:16];
					end
					4'(vid_pkg::reg_scroll_b): begin
						scroll_bx <= din[7:0];
						scroll_by <= din[23:16];
					end
					default: ;  // unmapped word
				endcase
			end
		end
	end

	// select delayed to meet the one-cycle memory read
	always_ff @(posedge clk) begin
		regs_q <= sel_regs;
		palette_q <= sel_palette;
		map_a_q <= sel_map_a;
		map_b_q <= sel_map_b;
		tiles_q <= sel_tiles;
		reg_idx_q <= reg_idx;
	end

	always_comb begin
		dout = '0;
		if (tiles_q) begin
			dout = rd_tiles;
		end else if (palette_q) begin
			dout = vid_pkg::cpu_data_t'(rd_palette);
		end else if (map_a_q) begin
			dout = vid_pkg::cpu_data_t'(rd_map_a);
		end else if (map_b_q) begin
			dout = vid_pkg::cpu_data_t'(rd_map_b);
		end else if (regs_q) begin
			case (reg_idx_q)
				4'(vid_pkg::reg_layer_en): dout = vid_pkg::cpu_data_t'(layer_en);
				4'(vid_pkg::reg_scroll_a): dout = {8'h00, scroll_ay, 8'h00, scroll_ax};
				4'(vid_pkg::reg_scroll_b): dout = {8'h00, scroll_by, 8'h00, scroll_bx};
				default: dout = '0;
			endcase
		end
	end

endmodule

/* verilog/vid_dpram.sv */
/*
 dual-port synchronous ram: one cpu write/read port and one read-only
 render port, both reads registered with one cycle of latency
 sized per use through width and depth
*/
`timescale 1ns/100ps

module vid_dpram #(
	parameter int width = 8,
	parameter int depth = 256
) (
	input logic clk,
	input logic wr_en,
	input logic [$clog2(depth)-1:0] wr_addr,
	input logic [width-1:0] wr_data,
	input logic [$clog2(depth)-1:0] a_addr,
	output logic [width-1:0] a_data,
	input logic [$clog2(depth)-1:0] b_addr,
	output logic [width-1:0] b_data
);

	logic [width-1:0] mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		a_data <= mem[a_addr];   // cpu readback
		b_data <= mem[b_addr];   // render side
	end

endmodule

/* verilog/vid_line_renderer.sv */
/*
 top level of the tile line renderer
 cpu slave port for registers and memories, frame_start/busy for frame
 control, and a credit-based pixel output of 24-bit colours
*/
`timescale 1ns/100ps

module vid_line_renderer (
	input logic clk,
	input logic reset,
	input vid_pkg::cpu_addr_t addr,
	input vid_pkg::cpu_data_t din,
	input logic [3:0] wstrb,
	input logic ren,
	output vid_pkg::cpu_data_t dout,
	output logic ready,
	input logic frame_start,
	output logic busy,
	output logic pix_valid,
	output vid_pkg::rgb_t pix_data,
	output logic pix_first,
	output logic pix_last,
	input logic pix_credit
);

	logic wr_palette, wr_map_a, wr_map_b, wr_tiles;
	vid_pkg::rgb_t rd_palette;
	vid_pkg::tile_no_t rd_map_a;
	vid_pkg::tile_no_t rd_map_b;
	vid_pkg::cpu_data_t rd_tiles;
	logic [1:0] layer_en;
	vid_pkg::scroll_t scroll_ax, scroll_ay, scroll_bx, scroll_by;
	vid_pkg::color_idx_t index_a;
	vid_pkg::color_idx_t index_b;

	vid_scan_if scan_bus ();

	vid_cpu_regs regs (
		.clk(clk), .reset(reset),
		.addr(addr), .din(din), .wstrb(wstrb), .ren(ren),
		.dout(dout), .ready(ready),
		.wr_palette(wr_palette), .wr_map_a(wr_map_a),
		.wr_map_b(wr_map_b), .wr_tiles(wr_tiles),
		.rd_palette(rd_palette), .rd_map_a(rd_map_a),
		.rd_map_b(rd_map_b), .rd_tiles(rd_tiles),
		.layer_en(layer_en),
		.scroll_ax(scroll_ax), .scroll_ay(scroll_ay),
		.scroll_bx(scroll_bx), .scroll_by(scroll_by)
	);

	vid_scan_ctrl scan_ctrl (
		.clk(clk), .reset(reset),
		.frame_start(frame_start), .pix_credit(pix_credit),
		.busy(busy), .scan(scan_bus.src)
	);

	vid_tile_fetch fetch_a (
		.clk(clk), .reset(reset), .scan(scan_bus.dst),
		.scroll_x(scroll_ax), .scroll_y(scroll_ay),
		.cpu_addr(addr), .cpu_din(din),
		.wr_map(wr_map_a), .wr_tiles(wr_tiles),
		.rd_map(rd_map_a), .rd_tiles(rd_tiles), .index(index_a)
	);

	// tile readback comes from layer a's copy only
	vid_tile_fetch fetch_b (
		.clk(clk), .reset(reset), .scan(scan_bus.dst),
		.scroll_x(scroll_bx), .scroll_y(scroll_by),
		.cpu_addr(addr), .cpu_din(din),
		.wr_map(wr_map_b), .wr_tiles(wr_tiles),
		.rd_map(rd_map_b), .rd_tiles(), .index(index_b)
	);

	vid_pixel_out pixel_out (
		.clk(clk), .reset(reset), .scan(scan_bus.dst),
		.layer_en(layer_en), .index_a(index_a), .index_b(index_b),
		.cpu_addr(addr), .cpu_din(din), .wr_palette(wr_palette),
		.rd_palette(rd_palette),
		.pix_valid(pix_valid), .pix_first(pix_first),
		.pix_last(pix_last), .pix_data(pix_data)
	);

endmodule

/* verilog/vid_pixel_out.sv */
/*
 layer composition and palette lookup
 layer a over layer b, index 0 is transparent, entry 0 is the backdrop;
 the scan tag is delayed to meet the palette read on the output
*/
`timescale 1ns/100ps

module vid_pixel_out (
	input logic clk,
	input logic reset,
	vid_scan_if.dst scan,
	input logic [1:0] layer_en,
	input vid_pkg::color_idx_t index_a,
	input vid_pkg::color_idx_t index_b,
	input vid_pkg::cpu_addr_t cpu_addr,
	input vid_pkg::cpu_data_t cpu_din,
	input logic wr_palette,
	output vid_pkg::rgb_t rd_palette,
	output logic pix_valid,
	output logic pix_first,
	output logic pix_last,
	output vid_pkg::rgb_t pix_data
);

	// last stage lines up with the palette data
	logic [vid_pkg::pix_latency-1:0] valid_pipe;
	logic [vid_pkg::pix_latency-1:0] first_pipe;
	logic [vid_pkg::pix_latency-1:0] last_pipe;
	logic [vid_pkg::pal_aw-1:0] pal_idx;

	always_comb begin
		if (layer_en[0] && index_a != '0)
			pal_idx = {1'b1, index_a};   // upper half for layer a
		else if (layer_en[1] && index_b != '0)
			pal_idx = {1'b0, index_b};
		else
			pal_idx = '0;
	end

	// read data register doubles as the output colour register
	vid_dpram #(
		.width($bits(vid_pkg::rgb_t)),
		.depth(vid_pkg::pal_entries)
	) palette (
		.clk(clk),
		.wr_en(wr_palette),
		.wr_addr(cpu_addr[2 +: vid_pkg::pal_aw]),
		.wr_data(cpu_din[$bits(vid_pkg::rgb_t)-1:0]),
		.a_addr(cpu_addr[2 +: vid_pkg::pal_aw]),
		.a_data(rd_palette),
		.b_addr(pal_idx),
		.b_data(pix_data)
	);

	always_ff @(posedge clk) begin
		if (reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[vid_pkg::pix_latency-2:0], scan.valid};
	end

	always_ff @(posedge clk) begin
		first_pipe <= {first_pipe[vid_pkg::pix_latency-2:0], scan.first};
		last_pipe <= {last_pipe[vid_pkg::pix_latency-2:0], scan.last};
	end

	assign pix_valid = valid_pipe[vid_pkg::pix_latency-1];
	assign pix_first = first_pipe[vid_pkg::pix_latency-1];
	assign pix_last = last_pipe[vid_pkg::pix_latency-1];

endmodule

/* verilog/vid_pkg.sv */
/*
 constants, widths and register map of the tile line renderer
 compiled first; the rtl reaches it through vid_pkg:: names
*/
package vid_pkg;

	// screen and tile geometry
	localparam int screen_w = 64;
	localparam int screen_h = 32;
	localparam int tile_size = 8;
	localparam int tile_bits = $clog2(tile_size);
	localparam int map_dim = 16;            // tilemap entries per edge, wraps at 128 px
	localparam int map_bits = $clog2(map_dim);
	localparam int tile_count = 256;        // tile numbers an entry can hold

	// memory sizes
	localparam int map_entries = map_dim * map_dim;
	localparam int map_aw = $clog2(map_entries);
	localparam int tile_words = tile_count * tile_size; // one 32-bit word per tile row
	localparam int tile_aw = $clog2(tile_words);
	localparam int pal_entries = 32;        // 16 for layer b, 16 for layer a
	localparam int pal_aw = $clog2(pal_entries);

	// pixel output handshake
	localparam int credits_init = 4;
	localparam int pix_latency = 4;         // issue to pix_valid

	typedef logic [7:0] coord_t;
	typedef logic [7:0] scroll_t;
	typedef logic [3:0] color_idx_t;
	typedef logic [7:0] tile_no_t;
	typedef logic [23:0] rgb_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [31:0] cpu_data_t;
	typedef logic [2:0] credit_t;

	// register word indices, addr[5:2]
	localparam int reg_layer_en = 0;
	localparam int reg_scroll_a = 1;
	localparam int reg_scroll_b = 2;

	// region codes on addr[15:12]; addr[15] alone selects tile memory
	localparam int region_regs = 0;
	localparam int region_palette = 1;
	localparam int region_map_a = 2;
	localparam int region_map_b = 3;

	typedef enum logic [0:0] {idle, run} scan_state_t;

endpackage

/* verilog/vid_scan_ctrl.sv */
/*
 frame control and raster scan, one pixel per clock in raster order
 a pixel is issued only while the sink holds a credit; the scan stalls
 in place otherwise and resumes when pix_credit returns one
*/
`timescale 1ns/100ps

module vid_scan_ctrl (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic pix_credit,
	output logic busy,
	vid_scan_if.src scan
);

	vid_pkg::scan_state_t state;
	vid_pkg::coord_t x;
	vid_pkg::coord_t y;
	vid_pkg::credit_t credits;
	logic issue;
	logic end_of_line;
	logic end_of_frame;

	assign issue = (state == vid_pkg::run) && (credits != '0);
	assign end_of_line = (x == vid_pkg::coord_t'(vid_pkg::screen_w - 1));
	assign end_of_frame = end_of_line && (y == vid_pkg::coord_t'(vid_pkg::screen_h - 1));
	assign busy = (state == vid_pkg::run);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= vid_pkg::idle;
			x <= '0;
			y <= '0;
			credits <= vid_pkg::credit_t'(vid_pkg::credits_init);
			scan.valid <= 1'b0;
		end else begin
			// take one on issue, get one back per pulse
			credits <= credits + vid_pkg::credit_t'(pix_credit) - vid_pkg::credit_t'(issue);
			scan.valid <= issue;
			case (state)
				vid_pkg::idle: begin
					if (frame_start) begin
						state <= vid_pkg::run;
						x <= '0;
						y <= '0;
					end
				end
				vid_pkg::run: begin
					if (issue) begin
						if (end_of_line) begin
							x <= '0;
							if (end_of_frame)
								state <= vid_pkg::idle;  // frame_start ignored until here
							else
								y <= y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
					end
				end
				default: state <= vid_pkg::idle;
			endcase
		end
	end

	// tag payload, qualified by scan.valid
	always_ff @(posedge clk) begin
		if (issue) begin
			scan.x <= x;
			scan.y <= y;
			scan.first <= (x == '0) && (y == '0);
			scan.last <= end_of_line;
		end
	end

endmodule

/* verilog/vid_scan_if.sv */
/*
 per-pixel scan tag, issued once per accepted pixel
 scan control drives it, both tile fetches and the output stage read it
*/
`timescale 1ns/100ps

interface vid_scan_if;
	logic valid;             // one pixel issued this cycle
	vid_pkg::coord_t x;
	vid_pkg::coord_t y;
	logic first;             // pixel (0,0) of the frame
	logic last;              // last pixel of a line

	modport src (output valid, x, y, first, last);
	modport dst (input valid, x, y, first, last);
endinterface

/* verilog/vid_tile_fetch.sv */
/*
 one tile layer: scrolled position -> tilemap -> tile row -> colour index
 three cycles from issue to a registered index; instantiated per layer,
 each with its own tilemap and its own copy of tile memory
*/
`timescale 1ns/100ps

module vid_tile_fetch (
	input logic clk,
	input logic reset,
	vid_scan_if.dst scan,
	input vid_pkg::scroll_t scroll_x,
	input vid_pkg::scroll_t scroll_y,
	input vid_pkg::cpu_addr_t cpu_addr,
	input vid_pkg::cpu_data_t cpu_din,
	input logic wr_map,
	input logic wr_tiles,
	output vid_pkg::tile_no_t rd_map,
	output vid_pkg::cpu_data_t rd_tiles,
	output vid_pkg::color_idx_t index
);

	vid_pkg::coord_t sx;
	vid_pkg::coord_t sy;
	logic [vid_pkg::map_aw-1:0] map_addr;
	vid_pkg::tile_no_t tile_no;
	logic [vid_pkg::tile_bits-1:0] row_q;
	logic [vid_pkg::tile_bits-1:0] col_q;
	logic [vid_pkg::tile_bits-1:0] col_qq;
	logic [vid_pkg::tile_aw-1:0] tile_addr;
	vid_pkg::cpu_data_t tile_row;

	assign sx = scan.x + scroll_x;  // mod 256
	assign sy = scan.y + scroll_y;

	// bit 7 dropped, so the map repeats every 128 pixels
	assign map_addr = {sy[vid_pkg::tile_bits +: vid_pkg::map_bits],
		sx[vid_pkg::tile_bits +: vid_pkg::map_bits]};

	vid_dpram #(
		.width($bits(vid_pkg::tile_no_t)),
		.depth(vid_pkg::map_entries)
	) tilemap (
		.clk(clk),
		.wr_en(wr_map),
		.wr_addr(cpu_addr[2 +: vid_pkg::map_aw]),
		.wr_data(cpu_din[$bits(vid_pkg::tile_no_t)-1:0]),
		.a_addr(cpu_addr[2 +: vid_pkg::map_aw]),
		.a_data(rd_map),
		.b_addr(map_addr),
		.b_data(tile_no)
	);

	// pixel within the tile, carried alongside the memory reads
	always_ff @(posedge clk) begin
		row_q <= sy[vid_pkg::tile_bits-1:0];
		col_q <= sx[vid_pkg::tile_bits-1:0];
		col_qq <= col_q;
	end

	assign tile_addr = {tile_no, row_q};

	vid_dpram #(
		.width($bits(vid_pkg::cpu_data_t)),
		.depth(vid_pkg::tile_words)
	) tilemem (
		.clk(clk),
		.wr_en(wr_tiles),
		.wr_addr(cpu_addr[2 +: vid_pkg::tile_aw]),
		.wr_data(cpu_din),
		.a_addr(cpu_addr[2 +: vid_pkg::tile_aw]),
		.a_data(rd_tiles),
		.b_addr(tile_addr),
		.b_data(tile_row)
	);

	always_ff @(posedge clk) begin
		if (reset)
			index <= '0;  // transparent
		else
			index <= tile_row[col_qq * $bits(vid_pkg::color_idx_t) +: $bits(vid_pkg::color_idx_t)];
	end

endmodule
